/* build.f */
+incdir+include
hw/alu_pkg.sv
hw/vector_sr.sv
hw/alu_dispatch.sv
hw/alu_multiply.sv
hw/alu_add_sub.sv
hw/alu_logic_shift.sv
hw/alu_result_select.sv
hw/alu_top.sv
dv/alu_tb.sv

/* include/alu_tb_tasks.svh */
/*
  alu_tb_tasks
  Reference model and directed test tasks for the ALU testbench.
  Tasks issue ops and queue the expected results for the monitor.
*/

`ifndef ALU_TB_TASKS_SVH
`define ALU_TB_TASKS_SVH

// expected result straight from the opcode rules
function automatic logic [ALU_W-1:0] expected_result(input alu_op_e op,
		input logic [ALU_W-1:0] a, input logic [ALU_W-1:0] b);
	logic signed [2*ALU_W-1:0] prod_s;
	logic [2*ALU_W-1:0]        prod_u;
	logic [4:0]                sh;
	prod_s = $signed({{ALU_W{a[ALU_W-1]}}, a}) * $signed({{ALU_W{b[ALU_W-1]}}, b});
	prod_u = {{ALU_W{1'b0}}, a} * {{ALU_W{1'b0}}, b};
	sh     = b[4:0];  // only low 5 bits shift
	case (op)
		OP_ADD:   return a + b;
		OP_SUB:   return a - b;
		OP_SLT:   return ($signed(a) < $signed(b)) ? 1 : 0;
		OP_SLTU:  return (a < b) ? 1 : 0;
		OP_AND:   return a & b;
		OP_OR:    return a | b;
		OP_XOR:   return a ^ b;
		OP_SLL:   return a << sh;
		OP_SRL:   return a >> sh;
		OP_SRA:   return $signed(a) >>> sh;  // sign fill
		OP_MUL:   return prod_s[ALU_W-1:0];
		OP_MULH:  return prod_s[2*ALU_W-1:ALU_W];
		default:  return prod_u[2*ALU_W-1:ALU_W];  // mulhu
	endcase
endfunction

function automatic logic [ALU_W-1:0] corner(input int idx);
	case (idx)
		0:       return 32'h0000_0000;
		1:       return 32'hffff_ffff;   // all ones is -1
		2:       return 32'h8000_0000;   // most negative
		3:       return 32'h7fff_ffff;   // most positive
		default: return 32'h0000_0001;
	endcase
endfunction

// one op on the next cycle with its expected value queued
task automatic issue_op(input alu_op_e op, input logic [ALU_W-1:0] a,
		input logic [ALU_W-1:0] b);
	@(posedge clk_i);
	#1;
	valid_i = 1'b1;
	op_i    = op;
	a_i     = a;
	b_i     = b;
	exp_op_q.push_back(op);
	exp_res_q.push_back(expected_result(op, a, b));
	exp_cyc_q.push_back(cycle + ALU_LAT);  // exact arrival cycle
	issued_cnt++;
endtask

task automatic idle_cycle();
	@(posedge clk_i);
	#1;
	valid_i = 1'b0;
	op_i    = alu_op_e'($urandom_range(12, 0));  // junk under valid low
	a_i     = $urandom;
	b_i     = $urandom;
endtask

task automatic drain_pipeline();
	idle_cycle();
	while (exp_cyc_q.size() != 0) begin
		@(posedge clk_i);
	end
	repeat (2) @(posedge clk_i);  // room for a stray valid
endtask

task automatic test_reset();
	repeat (4) @(posedge clk_i);
	#1;
	check_cnt++;
	if (valid_o !== 1'b0 || result_o !== '0 || debug_o !== 1'b0) begin
		$display("CHECK FAILED @%0t: outputs not zero during reset", $time);
		error_cnt++;
	end
	repeat (4) @(posedge clk_i);
	#1;
	rst_i = 1'b0;  // held 8 cycles
	repeat (2) @(posedge clk_i);
	#1;
	check_cnt++;
	if (valid_o !== 1'b0 || result_o !== '0 || debug_o !== 1'b0) begin
		$display("CHECK FAILED @%0t: outputs not zero after reset", $time);
		error_cnt++;
	end
endtask

task automatic test_add_sub();
	alu_op_e ops [4];
	ops = '{OP_ADD, OP_SUB, OP_SLT, OP_SLTU};
	foreach (ops[k]) begin
		for (int i = 0; i < 5; i++) begin
			for (int j = 0; j < 5; j++) begin
				issue_op(ops[k], corner(i), corner(j));
			end
		end
		repeat (20) issue_op(ops[k], $urandom, $urandom);
	end
	drain_pipeline();
endtask

task automatic test_logic_shift();
	alu_op_e shifts [3];
	logic [ALU_W-1:0] a;
	shifts = '{OP_SLL, OP_SRL, OP_SRA};
	repeat (10) begin
		issue_op(OP_AND, $urandom, $urandom);
		issue_op(OP_OR, $urandom, $urandom);
		issue_op(OP_XOR, $urandom, $urandom);
	end
	foreach (shifts[k]) begin
		for (int n = 0; n < 12; n++) begin
			a = (n % 3 == 0) ? ($urandom | 32'h8000_0000) : $urandom;  // negative too
			issue_op(shifts[k], a, $urandom & 32'hffff_ffe0);  // by 0 with upper b bits set
			issue_op(shifts[k], a, 32'd1);
			issue_op(shifts[k], a, 32'd31);
			issue_op(shifts[k], a, $urandom);           // random amount
		end
		issue_op(shifts[k], 32'h8000_0000, 32'd31);
	end
	drain_pipeline();
endtask

task automatic test_multiply();
	alu_op_e ops [3];
	ops = '{OP_MUL, OP_MULH, OP_MULHU};
	foreach (ops[k]) begin
		for (int i = 0; i < 5; i++) begin
			for (int j = 0; j < 5; j++) begin
				issue_op(ops[k], corner(i), corner(j));
			end
		end
		repeat (30) issue_op(ops[k], $urandom, $urandom);
	end
	drain_pipeline();
endtask

// random mix with roughly one gap in four cycles
task automatic test_mixed_stream();
	repeat (300) begin
		if ($urandom_range(3, 0) != 0) begin
			issue_op(alu_op_e'($urandom_range(12, 0)), $urandom, $urandom);
		end else begin
			idle_cycle();
		end
	end
	drain_pipeline();
endtask

`endif

/* dv/alu_tb.sv */
/*
  alu_tb
  Testbench for the pipelined ALU. Clock, reset, DUT, a scoreboard
  queue checked by a monitor on every falling edge, a watchdog and
  the closing report. Directed tests come from the included tasks.
*/

`timescale 1ns/1ps

module alu_tb;

	import alu_pkg::*;

	localparam int unsigned SEED = 32'h48a7cba0;

	logic             clk_i = 1'b0;
	logic             rst_i;
	logic             valid_i;
	alu_op_e          op_i;
	logic [ALU_W-1:0] a_i;
	logic [ALU_W-1:0] b_i;
	logic             valid_o;
	logic [ALU_W-1:0] result_o;
	logic             debug_o;

	// scoreboard, one entry per issued op
	alu_op_e          exp_op_q [$];
	logic [ALU_W-1:0] exp_res_q [$];
	int               exp_cyc_q [$];   // cycle in which valid_o must show

	int cycle      = 0;
	int issued_cnt = 0;
	int check_cnt  = 0;
	int error_cnt  = 0;

	always #2 clk_i = ~clk_i;  // 4 ns period

	always @(posedge clk_i) cycle <= cycle + 1;

	alu_top i_dut (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.valid_i  (valid_i),
		.op_i     (op_i),
		.a_i      (a_i),
		.b_i      (b_i),
		.valid_o  (valid_o),
		.result_o (result_o),
		.debug_o  (debug_o)
	);

	`include "alu_tb_tasks.svh"

	// monitor, outputs settled by the falling edge
	always @(negedge clk_i) begin
		if (!rst_i) begin
			if (debug_o !== 1'b0) begin
				$display("CHECK FAILED @%0t: debug_o set, multiplier mismatch", $time);
				error_cnt++;
			end
			if (exp_cyc_q.size() != 0 && exp_cyc_q[0] == cycle) begin
				check_cnt++;
				if (valid_o !== 1'b1) begin
					$display("CHECK FAILED @%0t: valid_o low when %s result due",
						$time, exp_op_q[0].name());
					error_cnt++;
				end else if (result_o !== exp_res_q[0]) begin
					$display("CHECK FAILED @%0t: %s result %h, expected %h",
						$time, exp_op_q[0].name(), result_o, exp_res_q[0]);
					error_cnt++;
				end
				void'(exp_op_q.pop_front());
				void'(exp_res_q.pop_front());
				void'(exp_cyc_q.pop_front());
			end else if (valid_o !== 1'b0) begin
				$display("CHECK FAILED @%0t: valid_o high with no result due", $time);
				error_cnt++;
			end
		end
	end

	// counts, then the verdict
	task automatic end_run();
		$display("checks run: %0d, errors: %0d", check_cnt, error_cnt);
		if (error_cnt == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	endtask

	// watchdog, budget grows with every issued op
	initial begin
		while (cycle <= 200 + 50 * issued_cnt) begin
			@(negedge clk_i);
		end
		$display("timeout: the run did not finish within %0d cycles", cycle);
		error_cnt++;
		end_run();
	end

	initial begin
		void'($urandom(SEED));  // one seed for the whole run
		rst_i   = 1'b1;
		valid_i = 1'b0;
		op_i    = OP_ADD;
		a_i     = '0;
		b_i     = '0;
		test_reset();
		test_add_sub();
		test_logic_shift();
		test_multiply();
		test_mixed_stream();
		end_run();
	end

endmodule

/* hw/alu_top.sv */
/*
  alu_top
  32-bit pipelined ALU. One operation per clock in, every result out
  after ALU_LAT clocks in issue order. debug_o flags a multiplier
  mismatch against the native product.
*/

`timescale 1ns/1ps

module alu_top (
	input  logic                        clk_i,
	input  logic                        rst_i,     // async, active high
	input  logic                        valid_i,
	input  alu_pkg::alu_op_e            op_i,
	input  logic [alu_pkg::ALU_W-1:0]   a_i,
	input  logic [alu_pkg::ALU_W-1:0]   b_i,
	output logic                        valid_o,
	output logic [alu_pkg::ALU_W-1:0]   result_o,
	output logic                        debug_o    // multiplier check failed
);

	import alu_pkg::*;

	// issued operation
	logic             iss_valid;
	alu_op_e          iss_op;
	logic [ALU_W-1:0] iss_a, iss_b;
	logic [MUL_W-1:0] mul_a, mul_b;   // extended operands
	// unit results
	logic [PROD_W-1:0] prod;
	logic [ALU_W-1:0]  add_res, logic_res;

	alu_dispatch i_dispatch (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.valid_i (valid_i),
		.op_i    (op_i),
		.a_i     (a_i),
		.b_i     (b_i),
		.valid_o (iss_valid),
		.op_o    (iss_op),
		.a_o     (iss_a),
		.b_o     (iss_b),
		.mul_a_o (mul_a),
		.mul_b_o (mul_b)
	);

	alu_multiply #(.DATA_W(MUL_W), .DEBUG_MODE(1)) i_multiply (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.a_i      (mul_a),
		.b_i      (mul_b),
		.result_o (prod),
		.debug_o  (debug_o)
	);

	alu_add_sub i_add_sub (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.op_i     (iss_op),
		.a_i      (iss_a),
		.b_i      (iss_b),
		.result_o (add_res)
	);

	alu_logic_shift i_logic_shift (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.op_i     (iss_op),
		.a_i      (iss_a),
		.b_i      (iss_b),
		.result_o (logic_res)
	);

	alu_result_select i_result_select (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.valid_i     (iss_valid),
		.op_i        (iss_op),
		.add_res_i   (add_res),
		.logic_res_i (logic_res),
		.prod_i      (prod),
		.valid_o     (valid_o),
		.result_o    (result_o)
	);

endmodule

/* hw/alu_result_select.sv */
/*
  alu_result_select
  Delays opcode, valid and the simple-unit results so they line up
  with the product, then picks the result by opcode class and
  registers it with valid.
*/

`timescale 1ns/1ps

module alu_result_select (
	input  logic                        clk_i,
	input  logic                        rst_i,        // async, active high
	input  logic                        valid_i,      // from issue reg
	input  alu_pkg::alu_op_e            op_i,
	input  logic [alu_pkg::ALU_W-1:0]   add_res_i,    // 1 clock after issue
	input  logic [alu_pkg::ALU_W-1:0]   logic_res_i,
	input  logic [alu_pkg::PROD_W-1:0]  prod_i,       // MUL_LAT clocks after issue
	output logic                        valid_o,
	output logic [alu_pkg::ALU_W-1:0]   result_o
);

	import alu_pkg::*;

	alu_op_e          op_d;
	logic             valid_d;
	logic [ALU_W-1:0] add_res_d, logic_res_d;
	logic [ALU_W-1:0] sel;

	// opcode and valid wait out the whole multiplier
	vector_sr #(.data_t(alu_op_e), .REGS(MUL_LAT)) i_op_sr (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.data_i (op_i),
		.data_o (op_d)
	);

	vector_sr #(.data_t(logic), .REGS(MUL_LAT)) i_valid_sr (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.data_i (valid_i),
		.data_o (valid_d)
	);

	// unit results are already UNIT_LAT in
	vector_sr #(.data_t(logic [ALU_W-1:0]), .REGS(MUL_LAT-UNIT_LAT)) i_add_sr (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.data_i (add_res_i),
		.data_o (add_res_d)
	);

	vector_sr #(.data_t(logic [ALU_W-1:0]), .REGS(MUL_LAT-UNIT_LAT)) i_logic_sr (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.data_i (logic_res_i),
		.data_o (logic_res_d)
	);

	always_comb begin
		case (op_d)
			OP_MUL:                          sel = prod_i[ALU_W-1:0];
			OP_MULH, OP_MULHU:               sel = prod_i[2*ALU_W-1:ALU_W];  // high word
			OP_ADD, OP_SUB, OP_SLT, OP_SLTU: sel = add_res_d;
			default:                         sel = logic_res_d;
		endcase
	end

	// output register, last clock of ALU_LAT
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			valid_o  <= 1'b0;
			result_o <= '0;
		end else begin
			valid_o  <= valid_d;
			result_o <= sel;  // not gated by valid
		end
	end

endmodule

/* hw/alu_logic_shift.sv */
/*
  alu_logic_shift
  Bitwise and, or, xor and barrel shifts of a by the low
  5 bits of b. Result registered, 1 clock.
*/

`timescale 1ns/1ps

module alu_logic_shift (
	input  logic                        clk_i,
	input  logic                        rst_i,     // async, active high
	input  alu_pkg::alu_op_e            op_i,
	input  logic [alu_pkg::ALU_W-1:0]   a_i,
	input  logic [alu_pkg::ALU_W-1:0]   b_i,       // also the shift amount
	output logic [alu_pkg::ALU_W-1:0]   result_o
);

	import alu_pkg::*;

	localparam int SH_W = $clog2(ALU_W);  // 5 bits for 32

	logic [SH_W-1:0]  shamt;
	logic [ALU_W-1:0] sll_res, srl_res, sra_res;
	logic [ALU_W-1:0] res;

	assign shamt = b_i[SH_W-1:0];  // upper bits of b ignored

	// shifters
	assign sll_res = a_i << shamt;
	assign srl_res = a_i >> shamt;
	assign sra_res = $signed(a_i) >>> shamt;  // fills with sign

	always_comb begin
		case (op_i)
			OP_OR:   res = a_i | b_i;
			OP_XOR:  res = a_i ^ b_i;
			OP_SLL:  res = sll_res;
			OP_SRL:  res = srl_res;
			OP_SRA:  res = sra_res;
			default: res = a_i & b_i;  // and
		endcase
	end

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			result_o <= '0;
		end else begin
			result_o <= res;
		end
	end

endmodule

/* hw/alu_add_sub.sv */
/*
  alu_add_sub
  One adder for add, subtract and the two set-less-than ops.
  Compares come from the difference's sign and carry out.
  Result registered, 1 clock.
*/

`timescale 1ns/1ps

module alu_add_sub (
	input  logic                        clk_i,
	input  logic                        rst_i,     // async, active high
	input  alu_pkg::alu_op_e            op_i,
	input  logic [alu_pkg::ALU_W-1:0]   a_i,
	input  logic [alu_pkg::ALU_W-1:0]   b_i,
	output logic [alu_pkg::ALU_W-1:0]   result_o
);

	import alu_pkg::*;

	logic             sub;       // everything but add subtracts
	logic [ALU_W-1:0] b_inv;
	logic [ALU_W:0]   sum;       // carry in the top bit
	logic             carry;
	logic             overflow;
	logic             lt_s, lt_u;
	logic [ALU_W-1:0] res;

	assign sub   = (op_i != OP_ADD);
	assign b_inv = b_i ^ {ALU_W{sub}};
	assign sum   = {1'b0, a_i} + {1'b0, b_inv} + {{ALU_W{1'b0}}, sub};  // a + ~b + 1
	assign carry = sum[ALU_W];

	// signed overflow of a - b
	assign overflow = (a_i[ALU_W-1] ^ b_i[ALU_W-1]) & (a_i[ALU_W-1] ^ sum[ALU_W-1]);

	assign lt_s = sum[ALU_W-1] ^ overflow;  // sign fixed for overflow
	assign lt_u = ~carry;                    // borrow means a < b

	always_comb begin
		case (op_i)
			OP_SLT:  res = {{(ALU_W-1){1'b0}}, lt_s};
			OP_SLTU: res = {{(ALU_W-1){1'b0}}, lt_u};
			default: res = sum[ALU_W-1:0];  // add, sub
		endcase
	end

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			result_o <= '0;
		end else begin
			result_o <= res;
		end
	end

endmodule

/* hw/alu_multiply.sv */
/*
  alu_multiply
  Signed multiplier built from four smaller partial products.
  3 stages over 4 registers. Input reg, partial products, inner sum
  with outer concat, then final add.
  DEBUG_MODE adds a native product check for simulation.
*/

`timescale 1ns/1ps

module alu_multiply #(
	parameter int DATA_W     = alu_pkg::MUL_W,  // operand width
	parameter int DEBUG_MODE = 0                // 1 adds native product compare
) (
	input  logic                  clk_i,
	input  logic                  rst_i,      // async, active high
	input  logic [DATA_W-1:0]     a_i,
	input  logic [DATA_W-1:0]     b_i,
	output logic [DATA_W*2-1:0]   result_o,   // a_i * b_i, 4 clocks later
	output logic                  debug_o     // high on mismatch
);

	localparam int HI_W   = DATA_W / 2;      // signed upper part
	localparam int LO_W   = DATA_W - HI_W;   // unsigned lower part
	localparam int MULT_W = LO_W * 2;        // partial product width
	localparam int DBL_W  = DATA_W * 2;

	logic signed [DATA_W-1:0] a_q, b_q;
	logic signed [HI_W-1:0]   a_hi, b_hi;
	logic signed [LO_W:0]     a_lo_ze, b_lo_ze;  // extra zero msb keeps them positive
	logic signed [MULT_W-1:0] mult_hi_hi, mult_hi_lo, mult_lo_hi, mult_lo_lo;
	logic signed [DBL_W-1:0]  inner_sum, outer_cat;

	// input register
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			a_q <= '0;
			b_q <= '0;
		end else begin
			a_q <= a_i;
			b_q <= b_i;
		end
	end

	// split operands
	assign a_hi    = a_q[DATA_W-1:LO_W];
	assign b_hi    = b_q[DATA_W-1:LO_W];
	assign a_lo_ze = {1'b0, a_q[LO_W-1:0]};
	assign b_lo_ze = {1'b0, b_q[LO_W-1:0]};

	// four partial products
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			mult_hi_hi <= '0;
			mult_hi_lo <= '0;
			mult_lo_hi <= '0;
			mult_lo_lo <= '0;
		end else begin
			mult_hi_hi <= a_hi * b_hi;
			mult_hi_lo <= a_hi * b_lo_ze;     // cross terms signed
			mult_lo_hi <= a_lo_ze * b_hi;
			mult_lo_lo <= a_lo_ze * b_lo_ze;  // always positive
		end
	end

	// inner terms summed and shifted, outer terms placed side by side
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			inner_sum <= '0;
			outer_cat <= '0;
		end else begin
			inner_sum <= (mult_hi_lo + mult_lo_hi) <<< LO_W;
			outer_cat <= {mult_hi_hi[HI_W*2-1:0], mult_lo_lo};  // hi_hi lands at 2*LO_W
		end
	end

	// final add
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			result_o <= '0;
		end else begin
			result_o <= outer_cat + inner_sum;
		end
	end

	generate
		if (DEBUG_MODE != 0) begin : g_debug
			logic signed [DBL_W-1:0] debug_mult, debug_mult_r;
			logic                    debug_q;

			assign debug_mult = a_q * b_q;  // native signed product

			// match the 3 stages after the input reg
			vector_sr #(
				.data_t (logic signed [DBL_W-1:0]),
				.REGS   (3)
			) i_debug_sr (
				.clk_i  (clk_i),
				.rst_i  (rst_i),
				.data_i (debug_mult),
				.data_o (debug_mult_r)
			);

			always_ff @(posedge clk_i or posedge rst_i) begin
				if (rst_i) begin
					debug_q <= 1'b0;
				end else begin
					debug_q <= (debug_mult_r != result_o);  // one clock behind result_o
				end
			end

			assign debug_o = debug_q;
		end else begin : g_no_debug
			assign debug_o = 1'b0;
		end
	endgenerate

endmodule

/* hw/alu_dispatch.sv */
/*
  alu_dispatch
  Issue register for the ALU. Captures opcode, operands and valid,
  and forms the 33-bit multiplier operands. These are zero extended
  for an unsigned high multiply and sign extended otherwise.
*/

`timescale 1ns/1ps

module alu_dispatch (
	input  logic                        clk_i,
	input  logic                        rst_i,     // async, active high
	// from outside
	input  logic                        valid_i,
	input  alu_pkg::alu_op_e            op_i,
	input  logic [alu_pkg::ALU_W-1:0]   a_i,
	input  logic [alu_pkg::ALU_W-1:0]   b_i,
	// issued operation
	output logic                        valid_o,
	output alu_pkg::alu_op_e            op_o,
	output logic [alu_pkg::ALU_W-1:0]   a_o,       // to add/sub and logic/shift
	output logic [alu_pkg::ALU_W-1:0]   b_o,
	output logic [alu_pkg::MUL_W-1:0]   mul_a_o,   // extended, to multiplier
	output logic [alu_pkg::MUL_W-1:0]   mul_b_o
);

	import alu_pkg::*;

	logic ext_a;  // extension bit for a
	logic ext_b;  // extension bit for b
	logic is_unsigned;

	// issue register
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			valid_o <= 1'b0;
			op_o    <= OP_ADD;
			a_o     <= '0;
			b_o     <= '0;
		end else begin
			valid_o <= valid_i;
			op_o    <= op_i;
			a_o     <= a_i;
			b_o     <= b_i;
		end
	end

	// only mulhu treats operands as unsigned
	assign is_unsigned = (op_o == OP_MULHU);

	// top bit is zero or copy of sign
	assign ext_a = is_unsigned ? 1'b0 : a_o[ALU_W-1];
	assign ext_b = is_unsigned ? 1'b0 : b_o[ALU_W-1];

	assign mul_a_o = {ext_a, a_o};
	assign mul_b_o = {ext_b, b_o};

endmodule

/* hw/vector_sr.sv */
/*
  vector_sr
  Delay line of REGS registers carrying a payload of any type.
  Every stage is cleared by the async reset.
  REGS of 0 gives a plain wire.
*/

`timescale 1ns/1ps

module vector_sr #(
	parameter type data_t = logic,  // payload type
	parameter int  REGS   = 1       // number of register stages
) (
	input  logic  clk_i,
	input  logic  rst_i,   // async, active high
	input  data_t data_i,
	output data_t data_o   // data_i delayed by REGS clocks
);

	generate
		if (REGS == 0) begin : g_bypass
			assign data_o = data_i;  // no stages
		end else begin : g_chain
			data_t sr_q [REGS];  // stage 0 nearest the input

			always_ff @(posedge clk_i or posedge rst_i) begin
				if (rst_i) begin
					for (int i = 0; i < REGS; i++) begin
						sr_q[i] <= data_t'(0);
					end
				end else begin
					sr_q[0] <= data_i;
					for (int i = 1; i < REGS; i++) begin
						sr_q[i] <= sr_q[i-1];  // shift along
					end
				end
			end

			assign data_o = sr_q[REGS-1];  // last stage out
		end
	endgenerate

endmodule

/* hw/alu_pkg.sv */
/*
  alu_pkg
  Shared widths, opcode encoding and pipeline depths for the 32-bit
  pipelined ALU datapath and its testbench.
*/

package alu_pkg;

	// data widths
	localparam int ALU_W  = 32;          // architectural word
	localparam int MUL_W  = ALU_W + 1;   // multiplier operand, room for sign or zero ext
	localparam int PROD_W = 2 * MUL_W;   // full signed product

	// opcode encoding
	typedef enum logic [3:0] {
		OP_ADD   = 4'd0,
		OP_SUB   = 4'd1,
		OP_SLT   = 4'd2,   // signed compare
		OP_SLTU  = 4'd3,   // unsigned compare
		OP_AND   = 4'd4,
		OP_OR    = 4'd5,
		OP_XOR   = 4'd6,
		OP_SLL   = 4'd7,
		OP_SRL   = 4'd8,
		OP_SRA   = 4'd9,
		OP_MUL   = 4'd10,  // low half of product
		OP_MULH  = 4'd11,  // high half, signed x signed
		OP_MULHU = 4'd12   // high half, unsigned x unsigned
	} alu_op_e;

	// pipeline depths in clock cycles
	localparam int MUL_LAT  = 4;            // multiplier operands in to product out
	localparam int UNIT_LAT = 1;            // add/sub and logic/shift units
	localparam int ALU_LAT  = MUL_LAT + 2;  // issue reg + multiplier + output reg

endpackage
